// File: logic/noc_pkg.sv
package noc_pkg;

  // ##########################################################################
  // Mesh geometry and router ports
  // ##########################################################################
  localparam int MESH_SIZE_X = 3;
  localparam int MESH_SIZE_Y = 3;
  localparam int COORD_W     = 2;  // Coordinate 3 is outside the mesh

  localparam int PORTS      = 5;
  localparam int PORT_IDX_W = $clog2(PORTS);

  localparam int PORT_X_PLUS  = 0;
  localparam int PORT_X_MINUS = 1;
  localparam int PORT_Y_PLUS  = 2;
  localparam int PORT_Y_MINUS = 3;
  localparam int PORT_LOCAL   = 4;

  // Input queue sizing
  localparam int BUFFER_DEPTH = 4;
  localparam int BUF_PTR_W    = $clog2(BUFFER_DEPTH);
  localparam int BUF_CNT_W    = $clog2(BUFFER_DEPTH + 1);

  // ##########################################################################
  // Flit and header formats
  // ##########################################################################
  localparam int TAG_W = 24;

  typedef enum logic {
    XY_ROUTING = 1'b0,
    YX_ROUTING = 1'b1
  } routing_mode_e;

  typedef struct packed {
    logic [COORD_W-1:0] dest_x;
    logic [COORD_W-1:0] dest_y;
    routing_mode_e      routing_mode;
    logic               invalid_destination;  // Set by the router, not the source
    logic [TAG_W-1:0]   tag;
  } header_t;

  localparam int PAYLOAD_W = $bits(header_t);

  typedef struct packed {
    logic                 head;
    logic                 tail;
    logic [PAYLOAD_W-1:0] payload;  // header_t on a head flit
  } flit_t;

  localparam int FLIT_W = $bits(flit_t);

  // One-hot output port, zero for no route
  typedef logic [PORTS-1:0] route_t;

endpackage

// File: logic/noc_input_buffer.sv
`timescale 1ns/1ps

module noc_input_buffer (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_valid,
  output logic           wr_ready,
  input  noc_pkg::flit_t wr_flit,
  output logic           rd_valid,
  input  logic           rd_ready,
  output noc_pkg::flit_t rd_flit
);

  noc_pkg::flit_t                   mem [noc_pkg::BUFFER_DEPTH];
  logic [noc_pkg::BUF_PTR_W-1:0]    wr_ptr;
  logic [noc_pkg::BUF_PTR_W-1:0]    rd_ptr;
  logic [noc_pkg::BUF_CNT_W-1:0]    count;
  logic                             push;
  logic                             pull;

  function automatic logic [noc_pkg::BUF_PTR_W-1:0] next_ptr(
    input logic [noc_pkg::BUF_PTR_W-1:0] ptr
  );
    if (ptr == noc_pkg::BUF_PTR_W'(noc_pkg::BUFFER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign rd_valid = (count != '0);
  assign rd_flit  = mem[rd_ptr];  // Head of queue
  assign pull     = rd_valid && rd_ready;
  // Full queue still accepts while the head leaves
  assign wr_ready = (count != noc_pkg::BUF_CNT_W'(noc_pkg::BUFFER_DEPTH)) || pull;
  assign push     = wr_valid && wr_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pull) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/noc_route_selector.sv
`timescale 1ns/1ps

module noc_route_selector #(
  parameter int ROUTER_X = 0,
  parameter int ROUTER_Y = 0
)(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            buf_valid,
  input  noc_pkg::flit_t  buf_flit,
  input  logic            xfer_ready,
  output logic            pop,
  output noc_pkg::route_t request,
  output noc_pkg::route_t start_of_packet,
  output noc_pkg::route_t end_of_packet,
  output noc_pkg::flit_t  flit_out
);

  // ##########################################################################
  // Route computation
  // ##########################################################################
  function automatic logic outside_mesh(input noc_pkg::header_t hdr);
    return (int'(hdr.dest_x) >= noc_pkg::MESH_SIZE_X) ||
           (int'(hdr.dest_y) >= noc_pkg::MESH_SIZE_Y);
  endfunction

  function automatic noc_pkg::route_t select_route(input noc_pkg::header_t hdr);
    logic            x_plus;
    logic            x_minus;
    logic            y_plus;
    logic            y_minus;
    noc_pkg::route_t route;
    x_plus  = int'(hdr.dest_x) > ROUTER_X;
    x_minus = int'(hdr.dest_x) < ROUTER_X;
    y_plus  = int'(hdr.dest_y) > ROUTER_Y;
    y_minus = int'(hdr.dest_y) < ROUTER_Y;
    route   = '0;
    if (outside_mesh(hdr)) begin
      route[noc_pkg::PORT_LOCAL] = 1'b1;  // Undeliverable, hand to local
    end else if (hdr.routing_mode == noc_pkg::XY_ROUTING) begin
      case (1'b1)
        x_plus:  route[noc_pkg::PORT_X_PLUS]  = 1'b1;
        x_minus: route[noc_pkg::PORT_X_MINUS] = 1'b1;
        y_plus:  route[noc_pkg::PORT_Y_PLUS]  = 1'b1;
        y_minus: route[noc_pkg::PORT_Y_MINUS] = 1'b1;
        default: route[noc_pkg::PORT_LOCAL]   = 1'b1;
      endcase
    end else begin
      case (1'b1)
        y_plus:  route[noc_pkg::PORT_Y_PLUS]  = 1'b1;
        y_minus: route[noc_pkg::PORT_Y_MINUS] = 1'b1;
        x_plus:  route[noc_pkg::PORT_X_PLUS]  = 1'b1;
        x_minus: route[noc_pkg::PORT_X_MINUS] = 1'b1;
        default: route[noc_pkg::PORT_LOCAL]   = 1'b1;
      endcase
    end
    return route;
  endfunction

  function automatic noc_pkg::flit_t mark_flit(input noc_pkg::flit_t flit);
    noc_pkg::header_t hdr;
    noc_pkg::flit_t   result;
    hdr    = noc_pkg::header_t'(flit.payload);
    result = flit;
    if (flit.head && outside_mesh(hdr)) begin
      hdr.invalid_destination = 1'b1;
      result.payload          = hdr;
    end
    return result;
  endfunction

  noc_pkg::header_t head_hdr;
  noc_pkg::route_t  route_next;
  noc_pkg::route_t  route_q;
  noc_pkg::route_t  route;
  logic             head_valid;
  logic             head_xfer;
  logic             tail_xfer;

  assign head_hdr   = noc_pkg::header_t'(buf_flit.payload);
  assign head_valid = buf_valid && buf_flit.head;
  assign head_xfer  = head_valid && xfer_ready;
  assign tail_xfer  = buf_valid && xfer_ready && buf_flit.tail;
  assign route_next = select_route(head_hdr);
  assign route      = head_valid ? route_next : route_q;  // Body flits reuse the held route

  // Tail wins over head so a single-flit packet leaves no route behind
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_q <= '0;
    end else if (tail_xfer) begin
      route_q <= '0;
    end else if (head_xfer) begin
      route_q <= route_next;
    end
  end

  // ##########################################################################
  // Allocator strobes and outgoing flit
  // ##########################################################################
  assign pop             = xfer_ready;
  assign request         = route & {noc_pkg::PORTS{buf_valid}};
  assign start_of_packet = route & {noc_pkg::PORTS{head_valid}};
  assign end_of_packet   = route & {noc_pkg::PORTS{tail_xfer}};
  assign flit_out        = mark_flit(buf_flit);

endmodule

// File: logic/noc_switch_allocator.sv
`timescale 1ns/1ps

module noc_switch_allocator (
  input  logic                      clk,
  input  logic                      rst_n,
  input  noc_pkg::route_t           request         [noc_pkg::PORTS],
  input  noc_pkg::route_t           start_of_packet [noc_pkg::PORTS],
  input  noc_pkg::route_t           end_of_packet   [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0] grant           [noc_pkg::PORTS]
);

  // Round-robin pointer value just past a one-hot owner
  function automatic logic [noc_pkg::PORT_IDX_W-1:0] next_index(
    input logic [noc_pkg::PORTS-1:0] onehot
  );
    logic [noc_pkg::PORT_IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < noc_pkg::PORTS; i++) begin
      if (onehot[i]) begin
        idx = (i == noc_pkg::PORTS - 1) ? '0 : noc_pkg::PORT_IDX_W'(i + 1);
      end
    end
    return idx;
  endfunction

  // ##########################################################################
  // One arbiter per output port
  // ##########################################################################
  for (genvar o = 0; o < noc_pkg::PORTS; o++) begin : g_output
    logic [noc_pkg::PORTS-1:0]      owner_q;    // Nonzero while a packet holds the port
    logic [noc_pkg::PORT_IDX_W-1:0] ptr_q;
    logic [noc_pkg::PORTS-1:0]      candidate;
    logic [noc_pkg::PORTS-1:0]      tail_seen;
    logic [noc_pkg::PORTS-1:0]      pick;
    logic                           end_hit;

    // Transpose the per-input strobes onto this output
    always_comb begin
      for (int i = 0; i < noc_pkg::PORTS; i++) begin
        candidate[i] = request[i][o] && start_of_packet[i][o];
        tail_seen[i] = end_of_packet[i][o];
      end
    end

    // First head at or after the pointer
    always_comb begin
      int idx;
      pick = '0;
      for (int k = 0; k < noc_pkg::PORTS; k++) begin
        idx = (int'(ptr_q) + k) % noc_pkg::PORTS;
        if ((pick == '0) && candidate[idx]) begin
          pick[idx] = 1'b1;
        end
      end
    end

    assign grant[o] = (owner_q != '0) ? owner_q : pick;  // Free port grants at once
    assign end_hit  = |(grant[o] & tail_seen);

    // Grant locks as soon as it is given and holds the port until the tail
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        owner_q <= '0;
        ptr_q   <= '0;
      end else if (end_hit) begin
        owner_q <= '0;
        ptr_q   <= next_index(grant[o]);
      end else begin
        owner_q <= grant[o];
      end
    end
  end

endmodule

// File: logic/noc_crossbar.sv
`timescale 1ns/1ps

module noc_crossbar (
  input  logic [noc_pkg::PORTS-1:0] grant      [noc_pkg::PORTS],
  input  logic [noc_pkg::PORTS-1:0] buf_valid,
  input  noc_pkg::flit_t            flit_in    [noc_pkg::PORTS],
  input  logic [noc_pkg::PORTS-1:0] out_ready,
  output logic [noc_pkg::PORTS-1:0] out_valid,
  output noc_pkg::flit_t            out_flit   [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0] xfer_ready
);

  // Output side, one-hot AND-OR select
  always_comb begin
    logic [noc_pkg::FLIT_W-1:0] acc;
    for (int o = 0; o < noc_pkg::PORTS; o++) begin
      out_valid[o] = |(grant[o] & buf_valid);
      acc = '0;
      for (int i = 0; i < noc_pkg::PORTS; i++) begin
        acc = acc | ({noc_pkg::FLIT_W{grant[o][i]}} & flit_in[i]);
      end
      out_flit[o] = noc_pkg::flit_t'(acc);
    end
  end

  // Input side, ready from whichever output grants it
  always_comb begin
    for (int i = 0; i < noc_pkg::PORTS; i++) begin
      xfer_ready[i] = 1'b0;
      for (int o = 0; o < noc_pkg::PORTS; o++) begin
        xfer_ready[i] = xfer_ready[i] | (grant[o][i] & out_ready[o]);
      end
    end
  end

endmodule

// File: logic/noc_router.sv
`timescale 1ns/1ps

module noc_router #(
  parameter int ROUTER_X = 1,
  parameter int ROUTER_Y = 1
)(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [noc_pkg::PORTS-1:0] in_valid,
  output logic [noc_pkg::PORTS-1:0] in_ready,
  input  noc_pkg::flit_t            in_flit   [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0] out_valid,
  input  logic [noc_pkg::PORTS-1:0] out_ready,
  output noc_pkg::flit_t            out_flit  [noc_pkg::PORTS]
);

  logic [noc_pkg::PORTS-1:0] buf_valid;
  noc_pkg::flit_t            buf_flit        [noc_pkg::PORTS];
  logic [noc_pkg::PORTS-1:0] pop;
  logic [noc_pkg::PORTS-1:0] xfer_ready;
  noc_pkg::flit_t            sel_flit        [noc_pkg::PORTS];  // Flit after marking
  noc_pkg::route_t           request         [noc_pkg::PORTS];
  noc_pkg::route_t           start_of_packet [noc_pkg::PORTS];
  noc_pkg::route_t           end_of_packet   [noc_pkg::PORTS];
  logic [noc_pkg::PORTS-1:0] grant           [noc_pkg::PORTS];  // Indexed by output

  // ##########################################################################
  // Per-input queue and route selection
  // ##########################################################################
  for (genvar i = 0; i < noc_pkg::PORTS; i++) begin : g_input
    noc_input_buffer u_buffer (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (in_valid[i]),
      .wr_ready (in_ready[i]),
      .wr_flit  (in_flit[i]),
      .rd_valid (buf_valid[i]),
      .rd_ready (pop[i]),
      .rd_flit  (buf_flit[i])
    );

    noc_route_selector #(
      .ROUTER_X (ROUTER_X),
      .ROUTER_Y (ROUTER_Y)
    ) u_selector (
      .clk             (clk),
      .rst_n           (rst_n),
      .buf_valid       (buf_valid[i]),
      .buf_flit        (buf_flit[i]),
      .xfer_ready      (xfer_ready[i]),
      .pop             (pop[i]),
      .request         (request[i]),
      .start_of_packet (start_of_packet[i]),
      .end_of_packet   (end_of_packet[i]),
      .flit_out        (sel_flit[i])
    );
  end

  // ##########################################################################
  // Arbitration and switching
  // ##########################################################################
  noc_switch_allocator u_allocator (
    .clk             (clk),
    .rst_n           (rst_n),
    .request         (request),
    .start_of_packet (start_of_packet),
    .end_of_packet   (end_of_packet),
    .grant           (grant)
  );

  noc_crossbar u_crossbar (
    .grant      (grant),
    .buf_valid  (buf_valid),
    .flit_in    (sel_flit),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_flit   (out_flit),
    .xfer_ready (xfer_ready)
  );

endmodule

// File: tests/noc_router_props.sv
`timescale 1ns/1ps

module noc_router_props (
  input logic                      clk,
  input logic                      rst_n,
  input logic [noc_pkg::PORTS-1:0] out_valid,
  input logic [noc_pkg::PORTS-1:0] out_ready,
  input noc_pkg::flit_t            out_flit [noc_pkg::PORTS],
  input logic [noc_pkg::PORTS-1:0] grant    [noc_pkg::PORTS]
);

  reset_idle: assert property (@(posedge clk) !rst_n |=> out_valid == '0)
    else $error("out_valid high right after reset");

  // ##########################################################################
  // Per-output handshake and packet framing
  // ##########################################################################
  for (genvar o = 0; o < noc_pkg::PORTS; o++) begin : g_port
    logic in_pkt;  // Head sent, tail not yet

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        in_pkt <= 1'b0;
      end else if (out_valid[o] && out_ready[o]) begin
        in_pkt <= !out_flit[o].tail;
      end
    end

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_flit[o]))
      else $error("Output %0d dropped or changed a stalled flit", o);

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant[o]))
      else $error("Output %0d granted to more than one input", o);

    head_after_tail: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[o] && out_ready[o] && out_flit[o].head |-> !in_pkt)
      else $error("Output %0d started a packet before the previous tail", o);
  end

endmodule

// File: tests/tb_router.sv
`timescale 1ns/1ps

module tb_router;

  localparam int ROUTER_X    = 1;
  localparam int ROUTER_Y    = 1;
  localparam int MAX_FLITS   = 9 + 27 + 9 + 48 + 160;  // Upper bound over all tests
  localparam int CYCLE_LIMIT = 20 * MAX_FLITS + 200;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic [noc_pkg::PORTS-1:0] in_valid;
  logic [noc_pkg::PORTS-1:0] in_ready;
  noc_pkg::flit_t            in_flit  [noc_pkg::PORTS];
  logic [noc_pkg::PORTS-1:0] out_valid;
  logic [noc_pkg::PORTS-1:0] out_ready;
  noc_pkg::flit_t            out_flit [noc_pkg::PORTS];

  logic [31:0]    lfsr_state;
  logic           stall_en;
  int             port_q  [noc_pkg::PORTS][$];                  // Expected output, per source
  noc_pkg::flit_t sb      [noc_pkg::PORTS][noc_pkg::PORTS][$];  // Indexed [output][source]
  int             pkt_src [noc_pkg::PORTS];                     // Open packet's source or -1
  int             flits_sent;
  int             flits_seen;
  int             cycles;
  int             checks;
  int             errors;
  int             errors_mark;
  int             tests_run;
  int             tests_failed;

  noc_router #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

  bind noc_router noc_router_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit),
    .grant     (grant)
  );

  always #4 clk = ~clk;

  // ##########################################################################
  // Random source and reference model
  // ##########################################################################
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int expected_port(input noc_pkg::header_t hdr);
    int dx;
    int dy;
    int x_port;
    int y_port;
    int first;
    int second;
    dx = int'(hdr.dest_x);
    dy = int'(hdr.dest_y);
    if (dx >= noc_pkg::MESH_SIZE_X || dy >= noc_pkg::MESH_SIZE_Y) begin
      return noc_pkg::PORT_LOCAL;
    end
    x_port = (dx > ROUTER_X) ? noc_pkg::PORT_X_PLUS : (dx < ROUTER_X) ? noc_pkg::PORT_X_MINUS : -1;
    y_port = (dy > ROUTER_Y) ? noc_pkg::PORT_Y_PLUS : (dy < ROUTER_Y) ? noc_pkg::PORT_Y_MINUS : -1;
    first  = (hdr.routing_mode == noc_pkg::XY_ROUTING) ? x_port : y_port;
    second = (hdr.routing_mode == noc_pkg::XY_ROUTING) ? y_port : x_port;
    if (first >= 0) begin
      return first;
    end
    return (second >= 0) ? second : noc_pkg::PORT_LOCAL;
  endfunction

  function automatic noc_pkg::flit_t expected_flit(input noc_pkg::flit_t flit);
    noc_pkg::header_t hdr;
    noc_pkg::flit_t   result;
    hdr    = flit.payload;
    result = flit;
    if (flit.head && (int'(hdr.dest_x) >= noc_pkg::MESH_SIZE_X ||
                      int'(hdr.dest_y) >= noc_pkg::MESH_SIZE_Y)) begin
      hdr.invalid_destination = 1'b1;
      result.payload          = hdr;
    end
    return result;
  endfunction

  // ##########################################################################
  // Compare tasks
  // ##########################################################################
  task automatic check_flit(input string name, input noc_pkg::flit_t got,
                            input noc_pkg::flit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_port(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input logic [noc_pkg::PORTS-1:0] got,
                            input logic [noc_pkg::PORTS-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // ##########################################################################
  // Stimulus
  // ##########################################################################
  task automatic send_flit(input int port, input noc_pkg::flit_t flit);
    logic taken;
    in_valid[port] = 1'b1;
    in_flit[port]  = flit;
    do begin
      @(negedge clk);
      taken = in_ready[port];  // Inputs hold until the next edge
      @(posedge clk);
      #1;
    end while (!taken);
    in_valid[port] = 1'b0;
  endtask

  // Source index rides in the low payload bits of every flit
  task automatic send_packet(input int src, input int dx, input int dy,
                             input int mode_bit, input int len);
    noc_pkg::header_t hdr;
    noc_pkg::flit_t   flit;
    logic [31:0]      r;
    int               port;
    hdr.dest_x              = dx[noc_pkg::COORD_W-1:0];
    hdr.dest_y              = dy[noc_pkg::COORD_W-1:0];
    hdr.routing_mode        = mode_bit ? noc_pkg::YX_ROUTING : noc_pkg::XY_ROUTING;
    hdr.invalid_destination = 1'b0;
    r                       = rand_bits(21);
    hdr.tag                 = {r[20:0], src[2:0]};
    port                    = expected_port(hdr);
    for (int n = 0; n < len; n++) begin
      flit.head = (n == 0);
      flit.tail = (n == len - 1);
      if (n == 0) begin
        flit.payload = hdr;
      end else begin
        r            = rand_bits(27);
        flit.payload = {r[26:0], src[2:0]};
      end
      port_q[src].push_back(port);
      sb[port][src].push_back(expected_flit(flit));
      flits_sent++;
      send_flit(src, flit);
    end
  endtask

  task automatic contend_source(input int src);
    repeat (3) begin
      send_packet(src, ROUTER_X, ROUTER_Y, 0, 4);
    end
  endtask

  task automatic random_source(input int src);
    logic [31:0] r;
    repeat (8) begin
      r = rand_bits(7);
      send_packet(src, int'(r[6:5]), int'(r[4:3]), int'(r[2]), 1 + int'(r[1:0]));
    end
  endtask

  task automatic wait_drain();
    while (flits_seen < flits_sent) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != errors_mark) begin
      tests_failed++;
    end
    $display("%-20s %0d errors", name, errors - errors_mark);
    errors_mark = errors;
  endtask

  always @(posedge clk) begin
    logic [31:0] r;
    #1;
    if (stall_en) begin
      r         = rand_bits(noc_pkg::PORTS);
      out_ready = r[noc_pkg::PORTS-1:0];
    end else begin
      out_ready = '1;
    end
  end

  // ##########################################################################
  // Output monitor, sampled mid-cycle where everything is settled
  // ##########################################################################
  always @(negedge clk) begin
    int src;
    int exp_port;
    if (rst_n) begin
      for (int o = 0; o < noc_pkg::PORTS; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          flits_seen++;
          src = int'(out_flit[o].payload[2:0]);
          if (src >= noc_pkg::PORTS || port_q[src].size() == 0) begin
            errors++;
            $display("Output %0d delivered a flit that no input sent", o);
          end else begin
            exp_port = port_q[src].pop_front();
            check_port($sformatf("out port for input %0d", src), o, exp_port);
            check_flit($sformatf("out_flit[%0d]", o), out_flit[o], sb[exp_port][src].pop_front());
          end
          if (out_flit[o].head ? (pkt_src[o] != -1) : (pkt_src[o] != src)) begin
            errors++;
            $display("Output %0d mixed flits of two packets", o);
          end
          pkt_src[o] = out_flit[o].tail ? -1 : src;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d of %0d flits delivered",
               cycles, flits_seen, flits_sent);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr_state = 32'h1339;
    stall_en   = 1'b0;
    rst_n      = 1'b0;
    in_valid   = '0;
    out_ready  = '1;
    for (int p = 0; p < noc_pkg::PORTS; p++) begin
      in_flit[p] = '0;
      pkt_src[p] = -1;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_mask("out_valid", out_valid, '0);
    check_mask("in_ready", in_ready, '1);
    end_test("reset state");
    @(posedge clk);
    #1;

    for (int dx = 0; dx < noc_pkg::MESH_SIZE_X; dx++) begin
      for (int dy = 0; dy < noc_pkg::MESH_SIZE_Y; dy++) begin
        send_packet(noc_pkg::PORT_LOCAL, dx, dy, 0, 1);
      end
    end
    wait_drain();
    end_test("xy routing");

    for (int dx = 0; dx < noc_pkg::MESH_SIZE_X; dx++) begin
      for (int dy = 0; dy < noc_pkg::MESH_SIZE_Y; dy++) begin
        send_packet(noc_pkg::PORT_LOCAL, dx, dy, 1, 1 + int'(rand_bits(2)) % 3);
      end
    end
    wait_drain();
    end_test("yx routing");

    send_packet(noc_pkg::PORT_Y_MINUS, 3, 0, 0, 3);
    send_packet(noc_pkg::PORT_Y_MINUS, 0, 3, 1, 3);
    send_packet(noc_pkg::PORT_Y_MINUS, 3, 3, 0, 3);
    wait_drain();
    end_test("invalid destination");

    fork
      contend_source(noc_pkg::PORT_X_PLUS);
      contend_source(noc_pkg::PORT_X_MINUS);
      contend_source(noc_pkg::PORT_Y_PLUS);
      contend_source(noc_pkg::PORT_Y_MINUS);
    join
    wait_drain();
    end_test("contention");

    stall_en = 1'b1;  // Random out_ready on every output
    fork
      random_source(noc_pkg::PORT_X_PLUS);
      random_source(noc_pkg::PORT_X_MINUS);
      random_source(noc_pkg::PORT_Y_PLUS);
      random_source(noc_pkg::PORT_Y_MINUS);
      random_source(noc_pkg::PORT_LOCAL);
    join
    wait_drain();
    stall_en = 1'b0;
    end_test("back-pressure");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
logic/noc_pkg.sv
logic/noc_input_buffer.sv
logic/noc_route_selector.sv
logic/noc_switch_allocator.sv
logic/noc_crossbar.sv
logic/noc_router.sv
tests/noc_router_props.sv
tests/tb_router.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_router -f src.f --Mdir "$OBJ" -o sim_tb_router
status=$?
if [ $status -ne 0 ]; then
  echo "Compile failed with status $status"
  exit 1
fi

"./$OBJ/sim_tb_router" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  echo "TEST FAILED" >> "$LOG"
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation passed"
exit 0
